// ==== common/fpu_defines.svh ====
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Datapath and context sizes
`define FPU_NUM_LANES 4
`define FPU_NUM_WARPS 4
`define FPU_NW_BITS   2
`define FPU_TAG_BITS  4
`define FPU_FLAG_BITS 5

// Width of the rounding-mode field on the request
`define FPU_RND_BITS  3

// Rounding-field values that pick the variant inside a family
`define FPU_RNE 3'b000
`define FPU_RTZ 3'b001
`define FPU_RDN 3'b010
`define FPU_DYN 3'b111

// Quiet NaN returned when MIN/MAX sees two NaNs
`define FPU_CANON_NAN 32'h7fc00000

`endif

// ==== common/fpu_pkg.sv ====
`default_nettype none

`include "fpu_defines.svh"

package fpu_pkg;

    // Operation family as issued by the core
    typedef enum logic [3:0] {
        OP_SGNJ   = 4'd0,
        OP_MINMAX = 4'd1,
        OP_CMP    = 4'd2,
        OP_CLASS  = 4'd3,
        OP_MVXW   = 4'd4,
        OP_MVWX   = 4'd5
    } fpu_op_e;

    // Resolved lane command, family plus variant
    typedef enum logic [3:0] {
        CMD_SGNJ    = 4'd0,
        CMD_SGNJN   = 4'd1,
        CMD_SGNJX   = 4'd2,
        CMD_MIN     = 4'd3,
        CMD_MAX     = 4'd4,
        CMD_FEQ     = 4'd5,
        CMD_FLT     = 4'd6,
        CMD_FLE     = 4'd7,
        CMD_CLASS   = 4'd8,
        CMD_MVXW    = 4'd9,
        CMD_MVWX    = 4'd10,
        CMD_ILLEGAL = 4'd11
    } fpu_cmd_e;

    typedef struct packed {
        logic NV;  // Invalid operation
        logic DZ;  // Divide by zero
        logic OF;  // Overflow
        logic UF;  // Underflow
        logic NX;  // Inexact
    } fpu_fflags_t;

    typedef logic [`FPU_NUM_LANES-1:0][31:0] fpu_vec_t;

    typedef struct packed {
        fpu_cmd_e                 cmd;
        logic [`FPU_NW_BITS-1:0]  warp;
        logic [`FPU_TAG_BITS-1:0] tag;
        fpu_vec_t                 a;
        fpu_vec_t                 b;
    } fpu_req_meta_t;

    typedef struct packed {
        logic [`FPU_NW_BITS-1:0]  warp;
        logic [`FPU_TAG_BITS-1:0] tag;
        fpu_vec_t                 data;
        fpu_fflags_t              fflags;  // OR of all lanes
    } fpu_rsp_t;

endpackage

`default_nettype wire

// ==== design/fpu_fflags_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_fflags_csr (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    upd_valid_i,
    input  logic [`FPU_NW_BITS-1:0] upd_warp_i,
    input  fpu_pkg::fpu_fflags_t    upd_fflags_i,
    input  logic                    clear_i,
    input  logic [`FPU_NW_BITS-1:0] clear_warp_i,
    input  logic [`FPU_NW_BITS-1:0] read_warp_i,
    output fpu_pkg::fpu_fflags_t    read_fflags_o
);
    import fpu_pkg::*;

    fpu_fflags_t [`FPU_NUM_WARPS-1:0] flags_q;

    logic same_warp;

    assign same_warp = clear_i && (clear_warp_i == upd_warp_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            flags_q <= '0;
        end else begin
            if (clear_i) begin
                flags_q[clear_warp_i] <= '0;
            end
            // Later assignment wins, so a colliding update survives the clear
            if (upd_valid_i) begin
                if (same_warp) begin
                    flags_q[upd_warp_i] <= upd_fflags_i;
                end else begin
                    flags_q[upd_warp_i] <= flags_q[upd_warp_i] | upd_fflags_i;
                end
            end
        end
    end

    assign read_fflags_o = flags_q[read_warp_i];  // Combinational CSR read

    // Warp indexes must name an existing warp context
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (!upd_valid_i || upd_warp_i < `FPU_NUM_WARPS) &&
        (!clear_i || clear_warp_i < `FPU_NUM_WARPS) &&
        (read_warp_i < `FPU_NUM_WARPS))
        else $error("fpu_fflags_csr: warp index out of range");

endmodule

`default_nettype wire

// ==== design/fpu_op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_op_decode (
    input  fpu_pkg::fpu_op_e           op_i,
    input  logic [`FPU_RND_BITS-1:0]   rnd_i,
    output fpu_pkg::fpu_cmd_e          cmd_o
);
    import fpu_pkg::*;

    fpu_cmd_e cmd;

    always_comb begin
        cmd = CMD_ILLEGAL;
        case (op_i)
            OP_SGNJ: begin
                case (rnd_i)
                    `FPU_RNE: cmd = CMD_SGNJ;
                    `FPU_RTZ: cmd = CMD_SGNJN;
                    `FPU_RDN: cmd = CMD_SGNJX;
                    default:  cmd = CMD_ILLEGAL;
                endcase
            end
            OP_MINMAX: begin
                case (rnd_i)
                    `FPU_RNE: cmd = CMD_MIN;
                    `FPU_RTZ: cmd = CMD_MAX;
                    default:  cmd = CMD_ILLEGAL;
                endcase
            end
            OP_CMP: begin
                case (rnd_i)
                    `FPU_RDN: cmd = CMD_FLE;
                    `FPU_RTZ: cmd = CMD_FLT;
                    `FPU_RNE: cmd = CMD_FEQ;
                    default:  cmd = CMD_ILLEGAL;
                endcase
            end
            OP_CLASS: cmd = CMD_CLASS;  // Rounding field ignored
            OP_MVXW:  cmd = CMD_MVXW;
            OP_MVWX:  cmd = CMD_MVWX;
            default:  cmd = CMD_ILLEGAL;
        endcase

        // Dynamic rounding has no meaning for a rounded family here
        if (rnd_i == `FPU_DYN &&
            (op_i == OP_SGNJ || op_i == OP_MINMAX || op_i == OP_CMP)) begin
            cmd = CMD_ILLEGAL;
        end
    end

    assign cmd_o = cmd;

endmodule

`default_nettype wire

// ==== design/fpu_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fpu_pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_data_i,
    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_data_o
);

    logic valid_q;
    T     data_q;

    // Accept when empty or when the held entry leaves this cycle
    assign in_ready_o = ~valid_q | out_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

    // A stalled entry stays put until taken
    assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("fpu_pipe_reg: stalled output changed");

endmodule

`default_nettype wire

// ==== design/fpu_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_unit_top (
    input  logic                             clk,
    input  logic                             rst_n_i,
    input  logic                             req_valid_i,
    output logic                             req_ready_o,
    input  fpu_pkg::fpu_op_e                 req_op_i,
    input  logic [`FPU_RND_BITS-1:0]         req_rnd_i,
    input  logic [`FPU_NW_BITS-1:0]          req_warp_i,
    input  logic [`FPU_TAG_BITS-1:0]         req_tag_i,
    input  logic [`FPU_NUM_LANES-1:0][31:0]  req_a_i,
    input  logic [`FPU_NUM_LANES-1:0][31:0]  req_b_i,
    output logic                             commit_valid_o,
    input  logic                             commit_ready_i,
    output logic [`FPU_NW_BITS-1:0]          commit_warp_o,
    output logic [`FPU_TAG_BITS-1:0]         commit_tag_o,
    output logic [`FPU_NUM_LANES-1:0][31:0]  commit_data_o,
    output fpu_pkg::fpu_fflags_t             commit_fflags_o,
    input  logic [`FPU_NW_BITS-1:0]          csr_read_warp_i,
    input  logic                             csr_clear_i,
    input  logic [`FPU_NW_BITS-1:0]          csr_clear_warp_i,
    output fpu_pkg::fpu_fflags_t             csr_fflags_o
);
    import fpu_pkg::*;

    fpu_cmd_e      dec_cmd;
    fpu_req_meta_t s1_in;
    fpu_req_meta_t s1_out;
    logic          s1_valid;
    logic          s2_ready;
    fpu_rsp_t      s2_in;
    fpu_rsp_t      s2_out;

    logic [`FPU_NUM_LANES-1:0][31:0]               lane_result;
    logic [`FPU_NUM_LANES-1:0][`FPU_FLAG_BITS-1:0] lane_fflags;
    logic [`FPU_FLAG_BITS-1:0]                     merged_fflags;

    fpu_op_decode u_decode (.op_i(req_op_i), .rnd_i(req_rnd_i), .cmd_o(dec_cmd));

    assign s1_in.cmd  = dec_cmd;
    assign s1_in.warp = req_warp_i;
    assign s1_in.tag  = req_tag_i;
    assign s1_in.a    = req_a_i;
    assign s1_in.b    = req_b_i;

    fpu_pipe_reg #(.T(fpu_req_meta_t)) u_s1 (
        .clk(clk), .rst_n_i(rst_n_i),
        .in_valid_i(req_valid_i), .in_ready_o(req_ready_o), .in_data_i(s1_in),
        .out_valid_o(s1_valid), .out_ready_i(s2_ready), .out_data_o(s1_out)
    );

    for (genvar i = 0; i < `FPU_NUM_LANES; i++) begin : g_lane
        fpu_noncomp_lane u_lane (
            .cmd_i(s1_out.cmd), .a_i(s1_out.a[i]), .b_i(s1_out.b[i]),
            .result_o(lane_result[i]), .fflags_o(lane_fflags[i])
        );
    end

    always_comb begin
        merged_fflags = '0;
        for (int i = 0; i < `FPU_NUM_LANES; i++) begin
            merged_fflags = merged_fflags | lane_fflags[i];
        end
    end

    assign s2_in.warp   = s1_out.warp;
    assign s2_in.tag    = s1_out.tag;
    assign s2_in.data   = lane_result;
    assign s2_in.fflags = merged_fflags;

    fpu_pipe_reg #(.T(fpu_rsp_t)) u_s2 (
        .clk(clk), .rst_n_i(rst_n_i),
        .in_valid_i(s1_valid), .in_ready_o(s2_ready), .in_data_i(s2_in),
        .out_valid_o(commit_valid_o), .out_ready_i(commit_ready_i), .out_data_o(s2_out)
    );

    assign commit_warp_o   = s2_out.warp;
    assign commit_tag_o    = s2_out.tag;
    assign commit_data_o   = s2_out.data;
    assign commit_fflags_o = s2_out.fflags;

    fpu_fflags_csr u_fflags (
        .clk(clk), .rst_n_i(rst_n_i),
        .upd_valid_i(commit_valid_o && commit_ready_i),  // Flags land on commit
        .upd_warp_i(s2_out.warp), .upd_fflags_i(s2_out.fflags),
        .clear_i(csr_clear_i), .clear_warp_i(csr_clear_warp_i),
        .read_warp_i(csr_read_warp_i), .read_fflags_o(csr_fflags_o)
    );

endmodule

`default_nettype wire

// ==== fpu_datapath/fpu_noncomp_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module fpu_noncomp_lane (
    input  fpu_pkg::fpu_cmd_e    cmd_i,
    input  logic [31:0]          a_i,
    input  logic [31:0]          b_i,
    output logic [31:0]          result_o,
    output fpu_pkg::fpu_fflags_t fflags_o
);
    import fpu_pkg::*;

    // RISC-V class mask, one hot
    function automatic logic [9:0] class_mask(input logic [31:0] x);
        logic       exp_ones;
        logic       exp_zero;
        logic       mant_zero;
        logic [9:0] m;
        exp_ones  = &x[30:23];
        exp_zero  = ~|x[30:23];
        mant_zero = ~|x[22:0];
        m         = '0;
        if (exp_ones && !mant_zero) begin
            if (x[22]) m[9] = 1'b1;  // Quiet NaN
            else       m[8] = 1'b1;  // Signaling NaN
        end else if (exp_ones) begin
            if (x[31]) m[0] = 1'b1;
            else       m[7] = 1'b1;
        end else if (exp_zero && mant_zero) begin
            if (x[31]) m[3] = 1'b1;
            else       m[4] = 1'b1;
        end else if (exp_zero) begin
            if (x[31]) m[2] = 1'b1;
            else       m[5] = 1'b1;
        end else begin
            if (x[31]) m[1] = 1'b1;
            else       m[6] = 1'b1;
        end
        return m;
    endfunction

    logic [9:0] a_cls;
    logic [9:0] b_cls;
    logic       a_nan;
    logic       b_nan;
    logic       any_nan;
    logic       any_snan;
    logic       both_zero;
    logic       a_lt_b;
    logic       cmp_lt;
    logic       cmp_eq;

    assign a_cls     = class_mask(a_i);
    assign b_cls     = class_mask(b_i);
    assign a_nan     = a_cls[8] | a_cls[9];
    assign b_nan     = b_cls[8] | b_cls[9];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = a_cls[8] | b_cls[8];
    assign both_zero = (a_cls[3] | a_cls[4]) & (b_cls[3] | b_cls[4]);

    // Total order on non-NaN values, -0 sits below +0
    assign a_lt_b = (a_i[31] != b_i[31]) ? a_i[31] :
                    (a_i[31] ? (a_i[30:0] > b_i[30:0]) : (a_i[30:0] < b_i[30:0]));

    assign cmp_lt = a_lt_b & ~both_zero;  // Compares treat the zeros as equal
    assign cmp_eq = (a_i == b_i) | both_zero;

    always_comb begin
        result_o = '0;
        fflags_o = '0;
        case (cmd_i)
            CMD_SGNJ:  result_o = {b_i[31], a_i[30:0]};
            CMD_SGNJN: result_o = {~b_i[31], a_i[30:0]};
            CMD_SGNJX: result_o = {a_i[31] ^ b_i[31], a_i[30:0]};
            CMD_MIN, CMD_MAX: begin
                if (a_nan && b_nan) begin
                    result_o = `FPU_CANON_NAN;
                end else if (a_nan) begin
                    result_o = b_i;
                end else if (b_nan) begin
                    result_o = a_i;
                end else if (cmd_i == CMD_MIN) begin
                    result_o = a_lt_b ? a_i : b_i;
                end else begin
                    result_o = a_lt_b ? b_i : a_i;
                end
                fflags_o.NV = any_snan;
            end
            CMD_FEQ: begin
                result_o    = {31'd0, ~any_nan & cmp_eq};
                fflags_o.NV = any_snan;  // Quiet NaNs are fine for equality
            end
            CMD_FLT: begin
                result_o    = {31'd0, ~any_nan & cmp_lt};
                fflags_o.NV = any_nan;
            end
            CMD_FLE: begin
                result_o    = {31'd0, ~any_nan & (cmp_lt | cmp_eq)};
                fflags_o.NV = any_nan;
            end
            CMD_CLASS: result_o = {22'd0, a_cls};
            CMD_MVXW,
            CMD_MVWX:  result_o = a_i;  // Bit pattern moves unchanged
            default:   fflags_o.NV = 1'b1;
        endcase
    end

    // Command must come from the decoder's enum range
    assert property (@(cmd_i) cmd_i inside {[CMD_SGNJ:CMD_ILLEGAL]})
        else $error("fpu_noncomp_lane: command out of range");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the FPU testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_fpu_unit -Mdir obj_dir \
    && ./obj_dir/Vtb_fpu_unit > sim.log 2>&1 \
    || echo "run_sim: build or run step returned an error"

[ -f sim.log ] && cat sim.log
grep -q "Simulation PASSED" sim.log 2>/dev/null && echo "run_sim: pass" && exit 0 \
    || { echo "run_sim: fail"; exit 1; }

// ==== testbench/fpu_stimulus.txt ====
# R op rnd warp tag a0 a1 a2 a3 b0 b1 b2 b3, next line e0 e1 e2 e3 fflags (NV=10), all hex
# C warp clears that warp's fflags, F warp fflags checks csr_fflags_o
R 0 0 0 0 3f800000 bf800000 7f800001 0 c0000000 40000000 80000000 80000000
    bf800000 3f800000 ff800001 80000000 00
R 0 1 1 1 3f800000 bf800000 7f800001 0 c0000000 40000000 80000000 80000000
    3f800000 bf800000 7f800001 0 00
R 0 2 2 2 3f800000 bf800000 7f800001 0 c0000000 40000000 80000000 80000000
    bf800000 bf800000 ff800001 80000000 00
R 1 0 0 3 0 7fc00000 7fc00000 3f800000 80000000 40000000 ffc00000 bf800000
    80000000 40000000 7fc00000 bf800000 00
R 1 1 1 4 0 7fc00000 7fc00000 3f800000 80000000 40000000 ffc00000 bf800000
    0 40000000 7fc00000 3f800000 00
R 1 0 2 5 7f800001 3f800000 80000000 c0000000 3f800000 40000000 0 bf800000
    3f800000 3f800000 80000000 c0000000 10
R 1 1 3 6 7f800001 3f800000 80000000 c0000000 3f800000 40000000 0 bf800000
    3f800000 40000000 0 bf800000 10
R 2 0 0 7 3f800000 0 7fc00000 3f800000 3f800000 80000000 7fc00000 40000000
    1 1 0 0 00
R 2 0 1 8 7f800001 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000 3f800000
    0 1 1 1 10
R 2 1 2 9 3f800000 40000000 80000000 bf800000 40000000 3f800000 0 7fc00000
    1 0 0 0 10
R 2 2 3 a 3f800000 40000000 80000000 c0000000 40000000 3f800000 0 bf800000
    1 0 1 1 00
R 3 0 1 b ff800000 bf800000 80000001 80000000 0 0 0 0
    1 2 4 8 00
R 3 5 2 c 0 1 3f800000 7f800000 0 0 0 0
    10 20 40 80 00
R 3 0 3 d 7f800001 7fc00000 ffc00000 ff800001 0 0 0 0
    100 200 200 100 00
R 4 0 0 e 12345678 7f800001 80000000 deadbeef 0 0 0 0
    12345678 7f800001 80000000 deadbeef 00
F 0 00
F 1 10
F 2 10
F 3 10
C 1
C 2
# Illegal variants and an undefined op code, then a move on a cleared warp
R 0 7 2 f 3f800000 bf800000 0 7fc00000 40000000 40000000 40000000 40000000
    0 0 0 0 10
R 1 2 3 0 3f800000 bf800000 0 7fc00000 40000000 40000000 40000000 40000000
    0 0 0 0 10
R 6 0 0 1 3f800000 bf800000 0 7fc00000 40000000 40000000 40000000 40000000
    0 0 0 0 10
R 5 3 1 2 cafef00d 0 ffffffff 7fc00000 0 0 0 0
    cafef00d 0 ffffffff 7fc00000 00
F 0 10
F 1 00
F 2 10
F 3 10
C 3
F 3 00

// ==== testbench/tb_fpu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpu_defines.svh"

module tb_fpu_unit;
    import fpu_pkg::*;

    localparam int    CLK_HALF  = 4;
    localparam string STIM_FILE = "testbench/fpu_stimulus.txt";

    logic                     clk;
    logic                     rst_n_i;
    logic                     req_valid_i;
    logic                     req_ready_o;
    fpu_op_e                  req_op_i;
    logic [`FPU_RND_BITS-1:0] req_rnd_i;
    logic [`FPU_NW_BITS-1:0]  req_warp_i;
    logic [`FPU_TAG_BITS-1:0] req_tag_i;
    fpu_vec_t                 req_a_i;
    fpu_vec_t                 req_b_i;
    logic                     commit_valid_o;
    logic                     commit_ready_i;
    logic [`FPU_NW_BITS-1:0]  commit_warp_o;
    logic [`FPU_TAG_BITS-1:0] commit_tag_o;
    fpu_vec_t                 commit_data_o;
    fpu_fflags_t              commit_fflags_o;
    logic [`FPU_NW_BITS-1:0]  csr_read_warp_i;
    logic                     csr_clear_i;
    logic [`FPU_NW_BITS-1:0]  csr_clear_warp_i;
    fpu_fflags_t              csr_fflags_o;

    fpu_vec_t                 exp_data_q[$];
    fpu_fflags_t              exp_flags_q[$];
    logic [`FPU_TAG_BITS-1:0] exp_tag_q[$];
    logic [`FPU_NW_BITS-1:0]  exp_warp_q[$];
    fpu_fflags_t              warp_flags[`FPU_NUM_WARPS];  // Accumulated flags per warp

    logic [31:0] lfsr_state = 32'hbe74bbf3;
    int          data_errs  = 0;
    int          flag_errs  = 0;
    int          tag_errs   = 0;
    int          other_errs = 0;
    int          n_lines    = 0;
    int          n_sent     = 0;
    int          n_commits  = 0;

    fpu_unit_top dut (
        .clk(clk), .rst_n_i(rst_n_i),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_op_i(req_op_i),
        .req_rnd_i(req_rnd_i), .req_warp_i(req_warp_i), .req_tag_i(req_tag_i),
        .req_a_i(req_a_i), .req_b_i(req_b_i),
        .commit_valid_o(commit_valid_o), .commit_ready_i(commit_ready_i),
        .commit_warp_o(commit_warp_o), .commit_tag_o(commit_tag_o),
        .commit_data_o(commit_data_o), .commit_fflags_o(commit_fflags_o),
        .csr_read_warp_i(csr_read_warp_i), .csr_clear_i(csr_clear_i),
        .csr_clear_warp_i(csr_clear_warp_i), .csr_fflags_o(csr_fflags_o)
    );

    always #(CLK_HALF) clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic check_data(input fpu_vec_t got, input fpu_vec_t exp);
        for (int i = 0; i < `FPU_NUM_LANES; i++) begin
            if (got[i] !== exp[i]) begin
                $display("[FAIL] %0t ns: lane %0d data %h, expected %h", $time, i, got[i], exp[i]);
                data_errs++;
            end
        end
    endtask

    task automatic check_flags(input fpu_fflags_t got, input fpu_fflags_t exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s fflags %b, expected %b", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    task automatic check_tag(input logic [`FPU_TAG_BITS-1:0] got_tag,
                             input logic [`FPU_NW_BITS-1:0] got_warp,
                             input logic [`FPU_TAG_BITS-1:0] exp_tag,
                             input logic [`FPU_NW_BITS-1:0] exp_warp);
        if (got_tag !== exp_tag || got_warp !== exp_warp) begin
            $display("[FAIL] %0t ns: tag %h warp %0d, expected tag %h warp %0d",
                     $time, got_tag, got_warp, exp_tag, exp_warp);
            tag_errs++;
        end
    endtask

    task automatic take_commit();
        fpu_vec_t                 e_data;
        fpu_fflags_t              e_flags;
        logic [`FPU_TAG_BITS-1:0] e_tag;
        logic [`FPU_NW_BITS-1:0]  e_warp;
        n_commits++;
        if (exp_tag_q.size() == 0) begin
            $display("Commit with tag %h arrived while no request was outstanding", commit_tag_o);
            other_errs++;
        end else begin
            e_data  = exp_data_q.pop_front();
            e_flags = exp_flags_q.pop_front();
            e_tag   = exp_tag_q.pop_front();
            e_warp  = exp_warp_q.pop_front();
            check_tag(commit_tag_o, commit_warp_o, e_tag, e_warp);
            check_data(commit_data_o, e_data);
            check_flags(commit_fflags_o, e_flags, "commit");
            warp_flags[e_warp] = warp_flags[e_warp] | e_flags;
        end
    endtask

    // Random back-pressure and commit monitor
    always @(negedge clk) begin
        if (rst_n_i) begin
            lfsr_state     = lfsr_next(lfsr_state);
            commit_ready_i = lfsr_state[0];
            #1;
            if (commit_valid_o && commit_ready_i) begin
                take_commit();  // Transfer lands on the coming edge
            end
        end
    end

    task automatic send_request(input fpu_op_e op, input logic [`FPU_RND_BITS-1:0] rnd,
                                input logic [`FPU_NW_BITS-1:0] warp,
                                input logic [`FPU_TAG_BITS-1:0] tag,
                                input fpu_vec_t a, input fpu_vec_t b,
                                input fpu_vec_t e, input fpu_fflags_t f);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            req_valid_i = 1'b1;
            req_op_i    = op;
            req_rnd_i   = rnd;
            req_warp_i  = warp;
            req_tag_i   = tag;
            req_a_i     = a;
            req_b_i     = b;
            #1;
            if (req_ready_o) begin
                accepted = 1'b1;
                exp_data_q.push_back(e);
                exp_flags_q.push_back(f);
                exp_tag_q.push_back(tag);
                exp_warp_q.push_back(warp);
                n_sent++;
            end
        end
    endtask

    // Idle the request port until every outstanding commit has landed
    task automatic drain();
        @(negedge clk);
        req_valid_i = 1'b0;
        while (exp_tag_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic clear_warp(input logic [`FPU_NW_BITS-1:0] w);
        drain();
        csr_clear_i      = 1'b1;
        csr_clear_warp_i = w;
        warp_flags[w]    = '0;
        @(negedge clk);
        csr_clear_i = 1'b0;
    endtask

    task automatic read_csr(input logic [`FPU_NW_BITS-1:0] w, input fpu_fflags_t exp);
        drain();
        csr_read_warp_i = w;
        #1;
        check_flags(csr_fflags_o, warp_flags[w], "csr vs model");
        check_flags(csr_fflags_o, exp, "csr vs file");
    endtask

    initial begin
        int                       fd;
        int                       code;
        logic [8*8-1:0]           word;
        logic [8*256-1:0]         line;
        logic [3:0]               op_raw;
        logic [`FPU_RND_BITS-1:0] rnd_raw;
        logic [`FPU_NW_BITS-1:0]  warp_raw;
        logic [`FPU_TAG_BITS-1:0] tag_raw;
        logic [4:0]               flags_raw;
        logic [31:0]              lane_val;
        fpu_vec_t                 a_v;
        fpu_vec_t                 b_v;
        fpu_vec_t                 e_v;
        clk              = 1'b0;
        rst_n_i          = 1'b0;
        req_valid_i      = 1'b0;
        req_op_i         = OP_SGNJ;
        req_rnd_i        = '0;
        req_warp_i       = '0;
        req_tag_i        = '0;
        req_a_i          = '0;
        req_b_i          = '0;
        commit_ready_i   = 1'b0;
        csr_read_warp_i  = '0;
        csr_clear_i      = 1'b0;
        csr_clear_warp_i = '0;
        for (int w = 0; w < `FPU_NUM_WARPS; w++) begin
            warp_flags[w] = '0;
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) n_lines++;
            end
            $fclose(fd);
            fd = $fopen(STIM_FILE, "r");
            repeat (2) @(negedge clk);
            rst_n_i = 1'b1;
            while ($fscanf(fd, "%s", word) == 1) begin
                if (word == "#") begin
                    code = $fgets(line, fd);
                end else if (word == "R") begin
                    code = $fscanf(fd, "%h %h %h %h", op_raw, rnd_raw, warp_raw, tag_raw);
                    for (int i = 0; i < `FPU_NUM_LANES; i++) begin
                        code     = $fscanf(fd, "%h", lane_val);
                        a_v[i]   = lane_val;
                    end
                    for (int i = 0; i < `FPU_NUM_LANES; i++) begin
                        code     = $fscanf(fd, "%h", lane_val);
                        b_v[i]   = lane_val;
                    end
                    for (int i = 0; i < `FPU_NUM_LANES; i++) begin
                        code     = $fscanf(fd, "%h", lane_val);
                        e_v[i]   = lane_val;
                    end
                    code = $fscanf(fd, "%h", flags_raw);
                    send_request(fpu_op_e'(op_raw), rnd_raw, warp_raw, tag_raw,
                                 a_v, b_v, e_v, fpu_fflags_t'(flags_raw));
                end else if (word == "C") begin
                    code = $fscanf(fd, "%h", warp_raw);
                    clear_warp(warp_raw);
                end else if (word == "F") begin
                    code = $fscanf(fd, "%h %h", warp_raw, flags_raw);
                    read_csr(warp_raw, fpu_fflags_t'(flags_raw));
                end else begin
                    $display("Unknown line kind %s in the stimulus file", word);
                    other_errs++;
                end
            end
            $fclose(fd);
            drain();
            repeat (4) @(negedge clk);  // Catch a stray extra commit
            if (n_commits != n_sent) begin
                $display("Sent %0d requests but saw %0d commits", n_sent, n_commits);
                other_errs++;
            end
        end
        $display("Errors: data %0d, flags %0d, tag/warp %0d, other %0d",
                 data_errs, flag_errs, tag_errs, other_errs);
        if (data_errs + flag_errs + tag_errs + other_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 20 + 100) @(posedge clk);
        $display("Watchdog expired with %0d commits still outstanding", exp_tag_q.size());
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+common
common/fpu_pkg.sv
design/fpu_op_decode.sv
fpu_datapath/fpu_noncomp_lane.sv
design/fpu_pipe_reg.sv
design/fpu_fflags_csr.sv
design/fpu_unit_top.sv
testbench/tb_fpu_unit.sv
